// File: Bender.yml
package:
  name: vm_router

sources:
  - files:
      - verilog/stubPkg.sv
      - verilog/routerPkg.sv
      - verilog/linkReader.sv
      - verilog/stubSelect.sv
      - verilog/vmBinner.sv
      - verilog/vmRouter.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/vmRouterTb.sv

// File: dv/vmRouterCases.svh
`ifndef VM_ROUTER_CASES_SVH
`define VM_ROUTER_CASES_SVH

// one row per event in the order applied
typedef struct packed {
    logic [5:0]  count1;
    logic [5:0]  count2;
    logic [5:0]  count3;
    logic [7:0]  pulses;
    logic [2:0]  bx;
    logic [35:0] salt;
} eventRow_t;

localparam int eventCount = 12;

// each row holds the three link counts, the expected stubValid pulses and bx,
// and the xor salt applied to the random words of that event's memory region
eventRow_t eventTable [eventCount] = '{
    {6'd3,  6'd2,  6'd1,  8'd6,  3'd0, 36'h0_0000_0000},
    {6'd0,  6'd0,  6'd0,  8'd0,  3'd1, 36'h0_0000_0000},
    {6'd1,  6'd0,  6'd0,  8'd1,  3'd2, 36'hF_0000_0000},
    {6'd0,  6'd4,  6'd0,  8'd4,  3'd3, 36'h0_0FF0_0000},
    {6'd0,  6'd0,  6'd5,  8'd5,  3'd4, 36'h0_0001_C000},
    {6'd7,  6'd0,  6'd3,  8'd10, 3'd5, 36'hA_5A5A_5A5A},
    {6'd63, 6'd20, 6'd12, 8'd95, 3'd6, 36'h0_0000_0007},
    {6'd2,  6'd9,  6'd0,  8'd11, 3'd7, 36'h3_0000_0000},
    {6'd10, 6'd10, 6'd10, 8'd30, 3'd0, 36'h0_07E0_0000},
    {6'd0,  6'd1,  6'd1,  8'd2,  3'd1, 36'hF_FFFF_FFFF},
    {6'd16, 6'd0,  6'd0,  8'd16, 3'd2, 36'h5_0000_8000},
    {6'd5,  6'd6,  6'd7,  8'd18, 3'd3, 36'h0_0000_0000}
};

`endif

// File: dv/vmRouterTb.sv
`timescale 1ns/10ps
`default_nettype none

module vmRouterTb;

    localparam bit innerLayer = 1'b1;
    localparam bit oddSector  = 1'b1;
    localparam int memSize    = 6;
    localparam int addrWidth  = 3 + memSize;
    localparam int memDepth   = 1 << addrWidth;

    `include "vmRouterCases.svh"

    logic clk = 1'b0;
    logic rst_pipe;
    logic start;
    logic [memSize-1:0] linkCount1;
    logic [memSize-1:0] linkCount2;
    logic [memSize-1:0] linkCount3;
    logic [35:0] linkData1;
    logic [35:0] linkData2;
    logic [35:0] linkData3;
    logic [addrWidth-1:0] linkAddr1;
    logic [addrWidth-1:0] linkAddr2;
    logic [addrWidth-1:0] linkAddr3;
    logic [35:0] allStub;
    logic stubValid;
    logic [18:0] vmStub;
    logic [7:0] vmWrEn;
    logic done;

    logic [35:0] linkMem1 [memDepth];
    logic [35:0] linkMem2 [memDepth];
    logic [35:0] linkMem3 [memDepth];
    logic [addrWidth-1:0] heldAddr1;
    logic [addrWidth-1:0] heldAddr2;
    logic [addrWidth-1:0] heldAddr3;

    logic [35:0] expAllQ [$];
    logic [18:0] expVmQ [$];
    logic [7:0] expEnQ [$];
    logic [18:0] vmExpected;
    logic [7:0] enExpected;
    logic vmDue;
    logic timedOut;
    int errCount;
    int checkCount;
    int testCount;
    int pulseCount;
    int n;

    vmRouter #(
        .innerLayer (innerLayer),
        .oddSector  (oddSector),
        .memSize    (memSize)
    ) UUT (
        .clk        (clk),
        .rst_pipe   (rst_pipe),
        .start      (start),
        .linkCount1 (linkCount1),
        .linkCount2 (linkCount2),
        .linkCount3 (linkCount3),
        .linkData1  (linkData1),
        .linkData2  (linkData2),
        .linkData3  (linkData3),
        .linkAddr1  (linkAddr1),
        .linkAddr2  (linkAddr2),
        .linkAddr3  (linkAddr3),
        .allStub    (allStub),
        .stubValid  (stubValid),
        .vmStub     (vmStub),
        .vmWrEn     (vmWrEn),
        .done       (done)
    );

    always #5 clk = ~clk;

    // registered-read link memories with the address taken mid-cycle
    always @(negedge clk) begin
        heldAddr1 <= linkAddr1;
        heldAddr2 <= linkAddr2;
        heldAddr3 <= linkAddr3;
    end

    always @(posedge clk) begin
        #1;
        linkData1 <= linkMem1[heldAddr1];
        linkData2 <= linkMem2[heldAddr2];
        linkData3 <= linkMem3[heldAddr3];
    end

    ////////////////////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [35:0] randomStub();
        logic [63:0] r;
        r = {$urandom(), $urandom()};
        randomStub = r[35:0];
    endfunction

    // layer bits on top
    function automatic logic [35:0] rotateStub(input logic [35:0] s);
        rotateStub = {s[2:0], s[35:3]};
    endfunction

    function automatic logic [18:0] formVmStub(input logic [35:0] s, input logic [5:0] idx);
        logic [3:0] z;
        logic [2:0] fine;
        z    = innerLayer ? s[25:22] : s[24:21];
        fine = innerLayer ? s[14:12] : s[17:15];
        fine[2] = fine[2] ^ oddSector;
        formVmStub = {s[2:0], idx, 1'b0, z, fine, s[35:34]};
    endfunction

    function automatic logic [7:0] binEnable(input logic [35:0] s);
        logic [2:0] phi;
        logic [2:0] p;
        logic zb;
        phi = innerLayer ? s[16:14] : s[19:17];
        zb  = innerLayer ? s[26] : s[25];
        p   = phi - {2'b00, oddSector};
        // odd sector with phi 0 lands in no bin
        if (oddSector && phi == 3'd0)
            binEnable = 8'h00;
        else
            binEnable = 8'h01 << ((p / 2) * 2 + zb);
    endfunction

    function automatic logic [35:0] memWord(input int link, input logic [addrWidth-1:0] addr);
        case (link)
            1:       memWord = linkMem1[addr];
            2:       memWord = linkMem2[addr];
            default: memWord = linkMem3[addr];
        endcase
    endfunction

    task automatic fillRegion(input logic [2:0] bx, input logic [35:0] salt);
        logic [addrWidth-1:0] a;
        for (int i = 0; i < (1 << memSize); i++) begin
            a = {bx, i[memSize-1:0]};
            linkMem1[a] = randomStub() ^ salt;
            linkMem2[a] = randomStub() ^ salt;
            linkMem3[a] = randomStub() ^ salt;
        end
    endtask

    // link 1 first, then 2, then 3
    task automatic buildExpected(input eventRow_t row);
        logic [35:0] word;
        logic [5:0] idx;
        int cnt;
        idx = '0;
        for (int link = 1; link <= 3; link++) begin
            cnt = (link == 1) ? row.count1 : (link == 2) ? row.count2 : row.count3;
            for (int e = 0; e < cnt; e++) begin
                word = memWord(link, {row.bx, e[memSize-1:0]});
                expAllQ.push_back(rotateStub(word));
                expVmQ.push_back(formVmStub(word, idx));
                expEnQ.push_back(binEnable(word));
                idx++;
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // output monitor
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        if (rst_pipe) begin
            vmDue = 1'b0;
        end else begin
            checkCount++;
            if (vmDue) begin
                if (vmStub !== vmExpected) begin
                    $display("Error: vmStub got %h expected %h", vmStub, vmExpected);
                    errCount++;
                end
                if (vmWrEn !== enExpected) begin
                    $display("Error: vmWrEn got %h expected %h", vmWrEn, enExpected);
                    errCount++;
                end
            end else if (vmWrEn !== 8'h00) begin
                $display("Error: vmWrEn got %h expected %h", vmWrEn, 8'h00);
                errCount++;
            end
            vmDue = 1'b0;
            if (stubValid === 1'b1) begin
                pulseCount++;
                if (expAllQ.size() == 0) begin
                    $display("stubValid pulsed with no stub left to expect");
                    errCount++;
                end else begin
                    checkCount++;
                    if (allStub !== expAllQ[0]) begin
                        $display("Error: allStub got %h expected %h at stub %0d",
                                 allStub, expAllQ[0], pulseCount - 1);
                        errCount++;
                    end
                    vmExpected = expVmQ.pop_front();
                    enExpected = expEnQ.pop_front();
                    void'(expAllQ.pop_front());
                    vmDue = 1'b1;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // event sequence
    ////////////////////////////////////////////////////////////////////////////

    task automatic runEvent(input int idx);
        eventRow_t row;
        int cycles;
        int errBefore;
        logic seen;
        row = eventTable[idx];
        errBefore = errCount;
        @(posedge clk);
        #1;
        linkCount1 = row.count1;
        linkCount2 = row.count2;
        linkCount3 = row.count3;
        fillRegion(row.bx, row.salt);
        buildExpected(row);
        pulseCount = 0;
        @(posedge clk);
        #1;
        start = 1'b1;
        cycles = 0;
        seen = 1'b0;
        while (!seen && cycles < 16) begin
            @(posedge clk);
            #1;
            start = 1'b0;
            cycles++;
            seen = (done === 1'b1);
        end
        if (!seen) begin
            $display("event %0d: done never rose after the start strobe", idx);
            timedOut = 1'b1;
            return;
        end
        checkCount++;
        if (cycles != 4) begin
            $display("Error: done latency got %h expected %h", cycles, 4);
            errCount++;
        end
        cycles = 0;
        while (expAllQ.size() != 0 && cycles < 300) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (expAllQ.size() != 0) begin
            $display("event %0d: %0d stubs never came out", idx, expAllQ.size());
            timedOut = 1'b1;
            return;
        end
        // room for the last vm stub and any stray pulses
        repeat (8) @(posedge clk);
        #1;
        checkCount++;
        if (pulseCount != row.pulses) begin
            $display("Error: stubValid count got %h expected %h", pulseCount, row.pulses);
            errCount++;
        end
        checkCount++;
        if (linkAddr1[addrWidth-1 -: 3] !== row.bx || linkAddr2[addrWidth-1 -: 3] !== row.bx
            || linkAddr3[addrWidth-1 -: 3] !== row.bx) begin
            $display("Error: linkAddr bx got %h %h %h expected %h",
                     linkAddr1[addrWidth-1 -: 3], linkAddr2[addrWidth-1 -: 3],
                     linkAddr3[addrWidth-1 -: 3], row.bx);
            errCount++;
        end
        testCount++;
        $display("event %0d: counts %0d/%0d/%0d bx %0d, %0d stubs, %s", idx, row.count1,
                 row.count2, row.count3, row.bx, pulseCount,
                 (errCount == errBefore) ? "ok" : "FAILED");
    endtask

    initial begin
        void'($urandom(41416));
        rst_pipe   = 1'b1;
        start      = 1'b0;
        linkCount1 = '0;
        linkCount2 = '0;
        linkCount3 = '0;
        linkData1  = '0;
        linkData2  = '0;
        linkData3  = '0;
        vmDue      = 1'b0;
        timedOut   = 1'b0;
        errCount   = 0;
        checkCount = 0;
        testCount  = 0;
        pulseCount = 0;
        for (int b = 0; b < 8; b++)
            fillRegion(b[2:0], 36'h0);

        repeat (5) @(posedge clk);
        #1;
        checkCount++;
        testCount++;
        if (stubValid !== 1'b0 || vmWrEn !== 8'h00 || done !== 1'b0
            || UUT.reader.readValid !== 1'b0) begin
            $display("Error: reset stubValid %h vmWrEn %h done %h readValid %h expected 0",
                     stubValid, vmWrEn, done, UUT.reader.readValid);
            errCount++;
            $display("reset: FAILED");
        end else begin
            $display("reset: ok");
        end
        rst_pipe = 1'b0;

        for (n = 0; n < eventCount && !timedOut; n++)
            runEvent(n);

        $display("%0d tests, %0d checks, %0d errors%s", testCount, checkCount, errCount,
                 timedOut ? ", run stopped on a timeout" : "");
        if (errCount == 0 && !timedOut)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
+incdir+dv
verilog/stubPkg.sv
verilog/routerPkg.sv
verilog/linkReader.sv
verilog/stubSelect.sv
verilog/vmBinner.sv
verilog/vmRouter.sv
dv/vmRouterTb.sv

// File: verilog/linkReader.sv
`timescale 1ns/10ps
`default_nettype none

module linkReader #(
    parameter int memSize = 6
) (
    input  wire logic                                 clk,
    input  wire logic                                 rst_pipe,
    input  wire logic                                 start,
    input  wire logic [memSize-1:0]                   linkCount1,
    input  wire logic [memSize-1:0]                   linkCount2,
    input  wire logic [memSize-1:0]                   linkCount3,
    output logic      [stubPkg::bxWidth+memSize-1:0]  linkAddr1,
    output logic      [stubPkg::bxWidth+memSize-1:0]  linkAddr2,
    output logic      [stubPkg::bxWidth+memSize-1:0]  linkAddr3,
    output routerPkg::linkSel_e                       linkSel,
    output logic                                      readValid,
    output logic                                      firstClk
);

    logic [stubPkg::bxWidth-1:0] bx;
    logic [stubPkg::bxWidth-1:0] addrBx;
    logic [memSize-1:0] entry [3];
    logic [memSize-1:0] count [3];
    logic [memSize-1:0] nextEntry [3];
    logic [2:0] canAdvance;
    logic [2:0] grant;
    routerPkg::linkSel_e nextSel;
    logic scanning;

    assign count[0] = linkCount1;
    assign count[1] = linkCount2;
    assign count[2] = linkCount3;

    // all-ones entry sits before entry 0, so +1 wraps to the first stub
    always_comb begin
        for (int i = 0; i < 3; i++) begin
            nextEntry[i]  = entry[i] + 1'b1;
            canAdvance[i] = nextEntry[i] < count[i];
        end
    end

    // link 1 drains first, then 2, then 3
    assign grant[0] = canAdvance[0];
    assign grant[1] = canAdvance[1] & ~canAdvance[0];
    assign grant[2] = canAdvance[2] & ~|canAdvance[1:0];

    always_comb begin
        if (grant[0])
            nextSel = routerPkg::link1;
        else if (grant[1])
            nextSel = routerPkg::link2;
        else if (grant[2])
            nextSel = routerPkg::link3;
        else
            nextSel = routerPkg::linkNone;
    end

    ////////////////////////////////////////////////////////////////////////////
    // event counter and read addresses
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst_pipe) begin
            bx        <= '1;
            addrBx    <= '1;
            firstClk  <= 1'b0;
            scanning  <= 1'b0;
            readValid <= 1'b0;
            linkSel   <= routerPkg::linkNone;
            for (int i = 0; i < 3; i++)
                entry[i] <= '1;
        end else begin
            firstClk <= start;
            if (start)
                bx <= bx + 1'b1;

            if (firstClk) begin
                addrBx    <= bx;
                scanning  <= 1'b1;
                readValid <= 1'b0;
                linkSel   <= routerPkg::linkNone;
                for (int i = 0; i < 3; i++)
                    entry[i] <= '1;
            end else if (scanning && grant != '0) begin
                readValid <= 1'b1;
                linkSel   <= nextSel;
                for (int i = 0; i < 3; i++)
                    if (grant[i])
                        entry[i] <= nextEntry[i];
            end else begin
                // idle until the next firstClk
                scanning  <= 1'b0;
                readValid <= 1'b0;
                linkSel   <= routerPkg::linkNone;
            end
        end
    end

    assign linkAddr1 = {addrBx, entry[0]};
    assign linkAddr2 = {addrBx, entry[1]};
    assign linkAddr3 = {addrBx, entry[2]};

    // a granted read stays below that link's stub count
    assert property (@(posedge clk) disable iff (rst_pipe)
        readValid |-> linkSel != routerPkg::linkNone
                      && entry[linkSel - 1] < count[linkSel - 1]);

endmodule

`default_nettype wire

// File: verilog/routerPkg.sv
`default_nettype none

package routerPkg;

    // which input link a read came from
    typedef enum logic [1:0] {
        linkNone = 2'd0,
        link1    = 2'd1,
        link2    = 2'd2,
        link3    = 2'd3
    } linkSel_e;

    // bin names and the bit each one sets in the enable vector
    typedef enum logic [2:0] {
        phi1z1 = 3'd0,
        phi1z2 = 3'd1,
        phi2z1 = 3'd2,
        phi2z2 = 3'd3,
        phi3z1 = 3'd4,
        phi3z2 = 3'd5,
        phi4z1 = 3'd6,
        phi4z2 = 3'd7
    } vmBin_e;

    // start to done
    localparam int doneDelay = 4;

    // address change to stubValid
    localparam int readToStub = 3;

endpackage

`default_nettype wire

// File: verilog/stubPkg.sv
`default_nettype none

package stubPkg;

    localparam int stubWidth   = 36;
    localparam int vmStubWidth = 19;
    localparam int indexWidth  = 6;
    localparam int bxWidth     = 3;

    // lsb positions and widths of the link stub fields
    localparam int layerLoPos   = 0;
    localparam int layerWidth   = 3;
    localparam int bendHiPos    = 34;
    localparam int bendWidth    = 2;
    localparam int phiWidth     = 3;
    localparam int finePhiWidth = 3;
    localparam int zWidth       = 4;

    // inner barrel layers
    localparam int innerZBinPos    = 26;
    localparam int innerPhiPos     = 14;
    localparam int innerFinePhiPos = 12;
    localparam int innerZPos       = 22;

    // outer barrel layers
    localparam int outerZBinPos    = 25;
    localparam int outerPhiPos     = 17;
    localparam int outerFinePhiPos = 15;
    localparam int outerZPos       = 21;

    // all-stub carries the layer bits above the shifted-down rest
    localparam int allStubRotate = layerWidth;

endpackage

`default_nettype wire

// File: verilog/stubSelect.sv
`timescale 1ns/10ps
`default_nettype none

module stubSelect (
    input  wire logic                              clk,
    input  wire logic                              rst_pipe,
    input  wire logic                              firstClk,
    input  wire logic                              readValid,
    input  wire routerPkg::linkSel_e               linkSel,
    input  wire logic [stubPkg::stubWidth-1:0]     linkData1,
    input  wire logic [stubPkg::stubWidth-1:0]     linkData2,
    input  wire logic [stubPkg::stubWidth-1:0]     linkData3,
    output logic      [stubPkg::stubWidth-1:0]     stubReg,
    output logic      [stubPkg::stubWidth-1:0]     allStub,
    output logic      [stubPkg::indexWidth-1:0]    stubIndex
);

    routerPkg::linkSel_e linkSelD;
    logic [1:0] validD;

    // link choice lines up with the registered memory read
    always_ff @(posedge clk) begin
        if (rst_pipe) begin
            linkSelD  <= routerPkg::linkNone;
            validD    <= '0;
            stubIndex <= '0;
        end else begin
            linkSelD <= linkSel;
            validD   <= {validD[0], readValid};
            if (firstClk)
                stubIndex <= '0;
            else if (validD[1])
                stubIndex <= stubIndex + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        case (linkSelD)
            routerPkg::link1: stubReg <= linkData1;
            routerPkg::link2: stubReg <= linkData2;
            routerPkg::link3: stubReg <= linkData3;
            default:          stubReg <= stubReg;
        endcase
        // layer bits move to the top
        allStub <= {stubReg[stubPkg::allStubRotate-1:0],
                    stubReg[stubPkg::stubWidth-1:stubPkg::allStubRotate]};
    end

    // every delayed read names a link
    assert property (@(posedge clk) disable iff (rst_pipe)
        validD[0] |-> linkSelD != routerPkg::linkNone);

endmodule

`default_nettype wire

// File: verilog/vmBinner.sv
`timescale 1ns/10ps
`default_nettype none

module vmBinner #(
    parameter bit innerLayer = 1'b1,
    parameter bit oddSector  = 1'b0
) (
    input  wire logic                               clk,
    input  wire logic                               rst_pipe,
    input  wire logic                               stubValid,
    input  wire logic [stubPkg::stubWidth-1:0]      stubReg,
    input  wire logic [stubPkg::stubWidth-1:0]      allStub,
    input  wire logic [stubPkg::indexWidth-1:0]     stubIndex,
    output logic      [stubPkg::vmStubWidth-1:0]    vmStub,
    output logic      [7:0]                         vmWrEn
);

    // field positions for this layer type
    localparam int zBinPos    = innerLayer ? stubPkg::innerZBinPos : stubPkg::outerZBinPos;
    localparam int phiPos     = innerLayer ? stubPkg::innerPhiPos : stubPkg::outerPhiPos;
    localparam int finePhiPos = innerLayer ? stubPkg::innerFinePhiPos
                                           : stubPkg::outerFinePhiPos;
    localparam int zPos       = innerLayer ? stubPkg::innerZPos : stubPkg::outerZPos;

    // same fields as seen in the rotated all-stub
    localparam int rotZBinPos = zBinPos - stubPkg::allStubRotate;
    localparam int rotPhiPos  = phiPos - stubPkg::allStubRotate;

    logic [stubPkg::vmStubWidth-1:0] vmPre;
    logic [stubPkg::finePhiWidth-1:0] finePhi;
    logic [stubPkg::phiWidth-1:0] phiField;
    logic [stubPkg::phiWidth-1:0] phiAdj;
    logic zBit;
    logic hasBin;
    routerPkg::vmBin_e bin;
    logic [7:0] binEn;
    logic [7:0] binEnReg;
    logic validD;

    ////////////////////////////////////////////////////////////////////////////
    // vm stub
    ////////////////////////////////////////////////////////////////////////////

    assign finePhi = {stubReg[finePhiPos+stubPkg::finePhiWidth-1] ^ oddSector,
                      stubReg[finePhiPos +: stubPkg::finePhiWidth-1]};

    // built while the index still belongs to this stub
    always_ff @(posedge clk) begin
        vmPre  <= {stubReg[stubPkg::layerLoPos +: stubPkg::layerWidth],
                   stubIndex,
                   1'b0,
                   stubReg[zPos +: stubPkg::zWidth],
                   finePhi,
                   stubReg[stubPkg::bendHiPos +: stubPkg::bendWidth]};
        vmStub <= vmPre;
    end

    ////////////////////////////////////////////////////////////////////////////
    // bin select
    ////////////////////////////////////////////////////////////////////////////

    assign phiField = allStub[rotPhiPos +: stubPkg::phiWidth];
    assign zBit     = allStub[rotZBinPos];
    assign phiAdj   = phiField - {{(stubPkg::phiWidth-1){1'b0}}, oddSector};

    // odd sectors have no bin for phi 0
    assign hasBin = !(oddSector && phiField == '0);
    assign bin    = routerPkg::vmBin_e'({phiAdj[stubPkg::phiWidth-1 -: 2], zBit});
    assign binEn  = hasBin ? (8'b1 << bin) : 8'b0;

    always_ff @(posedge clk) begin
        binEnReg <= binEn;
    end

    always_ff @(posedge clk) begin
        if (rst_pipe)
            validD <= 1'b0;
        else
            validD <= stubValid;
    end

    assign vmWrEn = binEnReg & {8{validD}};

    // at most one bin per stub
    assert property (@(posedge clk) disable iff (rst_pipe)
        $onehot0(vmWrEn));

endmodule

`default_nettype wire

// File: verilog/vmRouter.sv
`timescale 1ns/10ps
`default_nettype none

module vmRouter #(
    parameter bit innerLayer = 1'b1,
    parameter bit oddSector  = 1'b0,
    parameter int memSize    = 6
) (
    input  wire logic                                 clk,
    input  wire logic                                 rst_pipe,
    input  wire logic                                 start,
    input  wire logic [memSize-1:0]                   linkCount1,
    input  wire logic [memSize-1:0]                   linkCount2,
    input  wire logic [memSize-1:0]                   linkCount3,
    input  wire logic [stubPkg::stubWidth-1:0]        linkData1,
    input  wire logic [stubPkg::stubWidth-1:0]        linkData2,
    input  wire logic [stubPkg::stubWidth-1:0]        linkData3,
    output logic      [stubPkg::bxWidth+memSize-1:0]  linkAddr1,
    output logic      [stubPkg::bxWidth+memSize-1:0]  linkAddr2,
    output logic      [stubPkg::bxWidth+memSize-1:0]  linkAddr3,
    output logic      [stubPkg::stubWidth-1:0]        allStub,
    output logic                                      stubValid,
    output logic      [stubPkg::vmStubWidth-1:0]      vmStub,
    output logic      [7:0]                           vmWrEn,
    output logic                                      done
);

    routerPkg::linkSel_e linkSel;
    logic readValid;
    logic firstClk;
    logic [stubPkg::stubWidth-1:0] stubReg;
    logic [stubPkg::indexWidth-1:0] stubIndex;
    logic [routerPkg::doneDelay-1:0] doneShift;
    logic [routerPkg::readToStub-1:0] validShift;

    // done and stubValid are plain delays
    always_ff @(posedge clk) begin
        if (rst_pipe) begin
            doneShift  <= '0;
            validShift <= '0;
        end else begin
            doneShift  <= {doneShift[routerPkg::doneDelay-2:0], start};
            validShift <= {validShift[routerPkg::readToStub-2:0], readValid};
        end
    end

    assign done      = doneShift[routerPkg::doneDelay-1];
    assign stubValid = validShift[routerPkg::readToStub-1];

    linkReader #(
        .memSize    (memSize)
    ) reader (
        .clk        (clk),
        .rst_pipe   (rst_pipe),
        .start      (start),
        .linkCount1 (linkCount1),
        .linkCount2 (linkCount2),
        .linkCount3 (linkCount3),
        .linkAddr1  (linkAddr1),
        .linkAddr2  (linkAddr2),
        .linkAddr3  (linkAddr3),
        .linkSel    (linkSel),
        .readValid  (readValid),
        .firstClk   (firstClk)
    );

    stubSelect select (
        .clk        (clk),
        .rst_pipe   (rst_pipe),
        .firstClk   (firstClk),
        .readValid  (readValid),
        .linkSel    (linkSel),
        .linkData1  (linkData1),
        .linkData2  (linkData2),
        .linkData3  (linkData3),
        .stubReg    (stubReg),
        .allStub    (allStub),
        .stubIndex  (stubIndex)
    );

    vmBinner #(
        .innerLayer (innerLayer),
        .oddSector  (oddSector)
    ) binner (
        .clk        (clk),
        .rst_pipe   (rst_pipe),
        .stubValid  (stubValid),
        .stubReg    (stubReg),
        .allStub    (allStub),
        .stubIndex  (stubIndex),
        .vmStub     (vmStub),
        .vmWrEn     (vmWrEn)
    );

endmodule

`default_nettype wire
